//--- list.f
+incdir+include
logic/isa_pkg.sv
logic/exec_pkg.sv
logic/alu_comb.sv
logic/int_calc.sv
logic/branch_cond.sv
logic/reg_file.sv
logic/execute.sv
logic/exec_top.sv
dv/tb_exec_top.sv

//--- dv/tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module tb_exec_top;

  localparam int NUM_INSNS   = 600;
  localparam int STALL_LIMIT = 20;

  logic            clk_i;
  logic            rst_i;
  isa_pkg::insn_t  ir_i;
  isa_pkg::word_t  pc_i;
  logic            reg_write_i;
  isa_pkg::word_t  result_o;
  exec_pkg::ccr_t  ccr_o;
  isa_pkg::word_t  pc_o;
  logic            pc_set_o;
  logic            halt_o;
  logic            stall_o;
  isa_pkg::insn_t  ir_o;

  integer          seed;
  isa_pkg::word_t  m_regs [`EXEC_NUM_REGS];
  exec_pkg::ccr_t  m_ccr;
  logic            m_halt;
  isa_pkg::word_t  exp_result;
  logic            exp_has_result; // result_o only defined for some types
  isa_pkg::word_t  exp_pc;
  logic            exp_pc_set;

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  exec_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ir_i        (ir_i),
    .pc_i        (pc_i),
    .reg_write_i (reg_write_i),
    .result_o    (result_o),
    .ccr_o       (ccr_o),
    .pc_o        (pc_o),
    .pc_set_o    (pc_set_o),
    .halt_o      (halt_o),
    .stall_o     (stall_o),
    .ir_o        (ir_o)
  );

  task automatic fail_run;
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input isa_pkg::word_t got,
                            input isa_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_ccr(input string name, input exec_pkg::ccr_t got,
                           input exec_pkg::ccr_t exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      fail_run();
    end
  endtask

  function automatic isa_pkg::word_t alu_ref(input logic [2:0] f, input isa_pkg::word_t a,
                                             input isa_pkg::word_t b);
    logic signed [31:0] sa;
    sa = a;
    case (f)
      3'd0:    return a + b;
      3'd1:    return a - b;
      3'd2:    return a & b;
      3'd3:    return a | b;
      3'd4:    return a ^ b;
      3'd5:    return a << b[4:0];
      3'd6:    return a >> b[4:0];
      default: return sa >>> b[4:0];
    endcase
  endfunction

  // signed divide built from magnitudes, quotient truncates toward zero
  function automatic isa_pkg::word_t int_ref(input logic [3:0] f, input isa_pkg::word_t a,
                                             input isa_pkg::word_t b);
    isa_pkg::word_t ma;
    isa_pkg::word_t mb;
    ma = a[31] ? -a : a;
    mb = b[31] ? -b : b;
    if ((f == 4'd1 || f == 4'd5) && b == '0)
      return '1;
    if ((f == 4'd2 || f == 4'd6) && b == '0)
      return a;
    case (f)
      4'd0, 4'd4: return a * b; // low half same for both signs
      4'd1:       return (a[31] ^ b[31]) ? -(ma / mb) : ma / mb;
      4'd2:       return a[31] ? -(ma % mb) : ma % mb;
      4'd5:       return a / b;
      4'd6:       return a % b;
      default:    return '0;
    endcase
  endfunction

  function automatic logic cond_ref(input logic [3:0] op, input exec_pkg::ccr_t c);
    case (op)
      4'd0:    return 1'b1;
      4'd1:    return c[0];
      4'd2:    return !c[0];
      4'd3:    return !c[2] && !c[0];
      4'd4:    return !c[1] && !c[0];
      4'd5:    return !c[1];
      4'd6:    return c[1] || c[0];
      4'd7:    return c[1];
      4'd8:    return !c[2];
      4'd9:    return c[2];
      4'd10:   return c[2] || c[0];
      default: return 1'b0;
    endcase
  endfunction

  task automatic reset_model;
    for (int i = 0; i < `EXEC_NUM_REGS; i++)
    begin
      m_regs[i] = '0;
    end
    m_ccr  = '0;
    m_halt = 1'b0;
  endtask

  task automatic run_model(input isa_pkg::insn_t insn, input logic rw,
                           input isa_pkg::word_t pc);
    logic [3:0]     typ;
    logic [3:0]     op;
    isa_pkg::word_t a;
    isa_pkg::word_t b;
    isa_pkg::word_t sval;
    isa_pkg::word_t offs;
    typ  = insn[31:28];
    op   = insn[27:24];
    a    = m_regs[insn[19:16]];
    b    = m_regs[insn[15:12]];
    sval = {{17{insn[15]}}, insn[15:1]};
    offs = sval << 2;
    exp_result     = '0;
    exp_has_result = 1'b1;
    exp_pc         = pc;
    exp_pc_set     = 1'b0;
    case (typ)
      isa_pkg::T_ALU:  exp_result = alu_ref(op[2:0], a, op[3] ? sval : b);
      isa_pkg::T_CMP:
      begin
        exp_result = a - b;
        m_ccr      = {a < b, $signed(a) < $signed(b), a == b};
      end
      isa_pkg::T_INT:  exp_result = int_ref({1'b0, op[2:0]}, a, op[3] ? sval : b);
      isa_pkg::T_INTU: exp_result = int_ref(op, a, b);
      isa_pkg::T_LOAD, isa_pkg::T_STORE:
        exp_result = insn[0] ? insn[63:32] : a + offs;
      isa_pkg::T_BRANCH:
      begin
        exp_has_result = 1'b0;
        exp_pc_set     = cond_ref(op, m_ccr);
        if (exp_pc_set)
          exp_pc = pc + offs;
      end
      isa_pkg::T_JUMP:
      begin
        exp_has_result = 1'b0;
        exp_pc_set     = 1'b1;
        exp_pc         = insn[0] ? insn[63:32] : a + offs;
      end
      isa_pkg::T_LDI:  exp_result = insn[0] ? insn[63:32] : {17'b0, insn[15:1]};
      isa_pkg::T_MOV:  exp_result = a;
      default:
      begin
        exp_has_result = 1'b0;
        if (op == 4'd4)
          m_halt = 1'b1;
      end
    endcase
    if (rw)
      m_regs[insn[23:20]] = exp_result;
  endtask

  task automatic gen_insn(output isa_pkg::insn_t insn, output logic rw);
    isa_pkg::word_t r;
    isa_pkg::word_t fields;
    isa_pkg::word_t ext;
    logic [7:0]     pick;
    logic [3:0]     typ;
    logic [3:0]     op;
    logic [3:0]     ra;
    r      = $random(seed);
    fields = $random(seed);
    ext    = $random(seed);
    pick   = r[31:24] % 8'd11;
    typ    = pick[3:0];
    ra     = 4'd1 + (r[19:16] % 4'd15); // r0 stays zero for divide by zero
    case (typ)
      isa_pkg::T_INH:  op = 4'd0; // nop here, halt is issued at the end
      isa_pkg::T_INT:  op = {r[23], 1'b0, r[21:20] % 2'd3};
      isa_pkg::T_INTU: op = 4'd4 + (r[21:20] % 2'd3);
      default:         op = r[23:20];
    endcase
    insn = {ext, typ, op, ra, fields[19:0]};
    rw   = (typ == isa_pkg::T_ALU) || (typ == isa_pkg::T_INT) || (typ == isa_pkg::T_INTU)
           || (typ == isa_pkg::T_LDI) || (typ == isa_pkg::T_MOV);
  endtask

  // entered 2 ns after a rising edge, returns at the same point
  task automatic issue(input isa_pkg::insn_t insn, input logic rw, input isa_pkg::word_t pc);
    logic is_int;
    logic waiting;
    int   n;
    is_int      = (insn[31:28] == isa_pkg::T_INT) || (insn[31:28] == isa_pkg::T_INTU);
    ir_i        = insn;
    pc_i        = pc;
    reg_write_i = rw;
    run_model(insn, rw, pc);
    n       = 0;
    waiting = 1'b1;
    while (waiting)
    begin
      @(negedge clk_i);
      check_flag("stall_o", stall_o, is_int && (n < `EXEC_INT_DELAY));
      if (n > 0)
        check_flag("pc_set_o", pc_set_o, 1'b0); // redirect pulse ends inside a stall
      if (!stall_o)
        waiting = 1'b0;
      else
      begin
        n++;
        if (n > STALL_LIMIT)
        begin
          $display("stall_o did not end within %0d cycles", STALL_LIMIT);
          fail_run();
        end
      end
    end
    @(posedge clk_i); // acceptance edge
    #1;
    if (exp_has_result)
      check_word("result_o", result_o, exp_result);
    check_word("pc_o", pc_o, exp_pc);
    check_flag("pc_set_o", pc_set_o, exp_pc_set);
    check_ccr("ccr_o", ccr_o, m_ccr);
    check_flag("halt_o", halt_o, m_halt);
    check_word("ir_o[31:0]", ir_o[31:0], insn[31:0]);
    check_word("ir_o[63:32]", ir_o[63:32], insn[63:32]);
    #1;
  endtask

  task automatic apply_reset;
    ir_i        = '0;
    pc_i        = '0;
    reg_write_i = 1'b0;
    rst_i       = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    reset_model();
  endtask

  task automatic check_reset_state;
    check_word("result_o", result_o, '0);
    check_word("pc_o", pc_o, '0);
    check_word("ir_o[31:0]", ir_o[31:0], '0);
    check_word("ir_o[63:32]", ir_o[63:32], '0);
    check_ccr("ccr_o", ccr_o, '0);
    check_flag("pc_set_o", pc_set_o, 1'b0);
    check_flag("halt_o", halt_o, 1'b0);
    check_flag("stall_o", stall_o, 1'b0);
  endtask

  initial
  begin
    isa_pkg::insn_t insn;
    isa_pkg::word_t pc;
    logic           rw;
    seed = 32'hcc77_6efa;
    apply_reset();
    check_reset_state();
    for (int i = 1; i < `EXEC_NUM_REGS; i++)
    begin
      insn = {isa_pkg::word_t'($random(seed)), 4'd9, 4'd0, 4'(i), 19'b0, 1'b1}; // ldi, ext form
      issue(insn, 1'b1, 32'h0000_1000);
    end
    for (int i = 0; i < NUM_INSNS; i++)
    begin
      gen_insn(insn, rw);
      pc      = $random(seed);
      pc[1:0] = 2'b00;
      issue(insn, rw, pc);
    end
    issue({32'h0, 4'd0, 4'd4, 24'h0}, 1'b0, 32'h0000_2000); // halt
    for (int i = 0; i < 20; i++)
    begin
      gen_insn(insn, rw);
      issue(insn, rw, 32'h0000_3000);
    end
    apply_reset();
    check_reset_state();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top (
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire isa_pkg::insn_t  ir_i,
  input  wire isa_pkg::word_t  pc_i,
  input  wire logic            reg_write_i,
  output wire isa_pkg::word_t  result_o,
  output wire exec_pkg::ccr_t  ccr_o,
  output wire isa_pkg::word_t  pc_o,
  output wire logic            pc_set_o,
  output wire logic            halt_o,
  output wire logic            stall_o,
  output wire isa_pkg::insn_t  ir_o
);

  wire isa_pkg::reg_idx_t rb_idx;
  wire isa_pkg::reg_idx_t rc_idx;
  wire isa_pkg::reg_idx_t wb_idx;
  wire isa_pkg::word_t    rd_data1;
  wire isa_pkg::word_t    rd_data2;
  wire logic              wb_en;

  assign rb_idx = ir_i[isa_pkg::RB_LSB +: isa_pkg::REG_IDX_W];
  assign rc_idx = ir_i[isa_pkg::RC_LSB +: isa_pkg::REG_IDX_W];
  assign wb_idx = ir_o[isa_pkg::RA_LSB +: isa_pkg::REG_IDX_W]; // ra of the retired insn

  reg_file u_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_addr1_i (rb_idx),
    .rd_addr2_i (rc_idx),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2),
    .wr_en_i    (wb_en),
    .wr_addr_i  (wb_idx),
    .wr_data_i  (result_o)
  );

  execute u_exec (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ir_i        (ir_i),
    .pc_i        (pc_i),
    .reg_data1_i (rd_data1),
    .reg_data2_i (rd_data2),
    .reg_write_i (reg_write_i),
    .result_o    (result_o),
    .reg_data1_o (),          // store data, no memory stage here
    .reg_write_o (wb_en),
    .ccr_o       (ccr_o),
    .halt_o      (halt_o),
    .stall_o     (stall_o),
    .ir_o        (ir_o),
    .pc_o        (pc_o),
    .pc_set_o    (pc_set_o)
  );

endmodule

`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module execute (
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire isa_pkg::insn_t  ir_i,
  input  wire isa_pkg::word_t  pc_i,
  input  wire isa_pkg::word_t  reg_data1_i,
  input  wire isa_pkg::word_t  reg_data2_i,
  input  wire logic            reg_write_i,
  output isa_pkg::word_t       result_o,
  output isa_pkg::word_t       reg_data1_o,
  output logic                 reg_write_o,
  output exec_pkg::ccr_t       ccr_o,
  output logic                 halt_o,
  output logic                 stall_o,
  output isa_pkg::insn_t       ir_o,
  output isa_pkg::word_t       pc_o,
  output logic                 pc_set_o
);

  isa_pkg::insn_type_t  ir_type;
  isa_pkg::op_t         ir_op;
  isa_pkg::imm_t        ir_imm;
  isa_pkg::word_t       ir_ext;
  isa_pkg::word_t       ir_sval;
  isa_pkg::word_t       ir_uval;
  isa_pkg::word_t       ir_offset;
  logic                 ir_size;

  exec_pkg::alu_func_t  alu_func;
  exec_pkg::int_func_t  int_func;
  isa_pkg::word_t       alu_in1;
  isa_pkg::word_t       alu_in2;
  isa_pkg::word_t       alu_out;
  isa_pkg::word_t       int_out;
  logic                 alu_c;
  logic                 alu_z;
  logic                 alu_n;
  logic                 alu_v;
  logic                 br_taken;

  isa_pkg::word_t       result_d;
  isa_pkg::word_t       pc_d;
  logic                 pc_set_d;
  exec_pkg::ccr_t       ccr_d;
  logic                 halt_d;

  exec_pkg::delay_t     delay_q;
  exec_pkg::delay_t     delay_d;
  logic                 int_insn;
  logic                 stall_start;

  assign ir_type   = isa_pkg::insn_type_t'(ir_i[isa_pkg::TYPE_LSB +: isa_pkg::TYPE_W]);
  assign ir_op     = ir_i[isa_pkg::OP_LSB +: isa_pkg::OP_W];
  assign ir_imm    = ir_i[isa_pkg::IMM_LSB +: isa_pkg::IMM_W];
  assign ir_ext    = ir_i[isa_pkg::EXT_LSB +: isa_pkg::WORD_W];
  assign ir_size   = ir_i[isa_pkg::SIZE_BIT];
  assign ir_sval   = {{(isa_pkg::WORD_W - isa_pkg::IMM_W){ir_imm[isa_pkg::IMM_W-1]}}, ir_imm};
  assign ir_uval   = {{(isa_pkg::WORD_W - isa_pkg::IMM_W){1'b0}}, ir_imm};
  assign ir_offset = {ir_sval[29:0], 2'b00}; // word offset

  assign int_insn    = (ir_type == isa_pkg::T_INT) || (ir_type == isa_pkg::T_INTU);
  assign stall_start = int_insn && (delay_q == '0);
  // high on the presenting cycle and while the counter is above one
  assign stall_o     = stall_start || (delay_q > exec_pkg::delay_t'(1));

  always_comb
  begin
    delay_d = delay_q;
    if (stall_start)
      delay_d = exec_pkg::delay_t'(`EXEC_INT_DELAY);
    else if (delay_q != '0)
      delay_d = delay_q - exec_pkg::delay_t'(1);
  end

  always_comb
  begin
    alu_in1  = reg_data1_i;
    alu_in2  = reg_data2_i;
    alu_func = exec_pkg::alu_func_t'(ir_op[2:0]);
    int_func = exec_pkg::INT_MUL;
    case (ir_type)
      isa_pkg::T_ALU:
      begin
        if (ir_op[3])
          alu_in2 = ir_sval;
      end
      isa_pkg::T_INT:
      begin
        int_func = exec_pkg::int_func_t'({1'b0, ir_op[2:0]});
        if (ir_op[3])
          alu_in2 = ir_sval;
      end
      isa_pkg::T_INTU:
        int_func = exec_pkg::int_func_t'(ir_op);
      isa_pkg::T_CMP:
        alu_func = exec_pkg::ALU_SUB;
      isa_pkg::T_LOAD, isa_pkg::T_STORE, isa_pkg::T_JUMP:
      begin
        alu_func = exec_pkg::ALU_ADD; // rb + offset
        alu_in2  = ir_offset;
      end
      isa_pkg::T_BRANCH:
      begin
        alu_func = exec_pkg::ALU_ADD;
        alu_in1  = pc_i;
        alu_in2  = ir_offset;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    case (ir_type)
      isa_pkg::T_INT, isa_pkg::T_INTU:
        result_d = int_out;
      isa_pkg::T_LOAD, isa_pkg::T_STORE:
        result_d = ir_size ? ir_ext : alu_out;
      isa_pkg::T_LDI:
        result_d = ir_size ? ir_ext : ir_uval;
      isa_pkg::T_MOV:
        result_d = reg_data1_i;
      default:
        result_d = alu_out;
    endcase
  end

  assign ccr_d  = (ir_type == isa_pkg::T_CMP) ? {alu_c, alu_n ^ alu_v, alu_z} : ccr_o;
  assign halt_d = halt_o || ((ir_type == isa_pkg::T_INH) && (ir_op == isa_pkg::HALT_OP));

  always_comb
  begin
    pc_d     = pc_i;
    pc_set_d = 1'b0;
    if (ir_type == isa_pkg::T_BRANCH && br_taken)
    begin
      pc_d     = alu_out;
      pc_set_d = 1'b1;
    end
    else if (ir_type == isa_pkg::T_JUMP)
    begin
      pc_d     = ir_size ? ir_ext : alu_out;
      pc_set_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      delay_q     <= '0;
      ir_o        <= '0;
      pc_o        <= '0;
      pc_set_o    <= 1'b0;
      result_o    <= '0;
      reg_data1_o <= '0;
      reg_write_o <= 1'b0;
      ccr_o       <= '0;
      halt_o      <= 1'b0;
    end
    else
    begin
      delay_q <= delay_d;
      if (stall_o)
      begin
        pc_set_o <= 1'b0; // keep the redirect a single pulse
      end
      else
      begin
        ir_o        <= ir_i;
        pc_o        <= pc_d;
        pc_set_o    <= pc_set_d;
        result_o    <= result_d;
        reg_data1_o <= reg_data1_i;
        reg_write_o <= reg_write_i;
        ccr_o       <= ccr_d;
        halt_o      <= halt_d;
      end
    end
  end

  alu_comb u_alu (
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .func_i (alu_func),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .z_o    (alu_z),
    .n_o    (alu_n),
    .v_o    (alu_v)
  );

  int_calc u_int (
    .func_i (int_func),
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .out_o  (int_out)
  );

  branch_cond u_br (
    .op_i    (ir_op),
    .ccr_i   (ccr_o), // codes left by earlier instructions
    .taken_o (br_taken)
  );

  a_no_redirect_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(pc_set_o) |-> !$past(stall_o));

  a_delay_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    delay_q <= exec_pkg::delay_t'(`EXEC_INT_DELAY));

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module reg_file (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire isa_pkg::reg_idx_t  rd_addr1_i,
  input  wire isa_pkg::reg_idx_t  rd_addr2_i,
  output isa_pkg::word_t          rd_data1_o,
  output isa_pkg::word_t          rd_data2_o,
  input  wire logic               wr_en_i,
  input  wire isa_pkg::reg_idx_t  wr_addr_i,
  input  wire isa_pkg::word_t     wr_data_i
);

  isa_pkg::word_t regs [`EXEC_NUM_REGS];

  logic hit1;
  logic hit2;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `EXEC_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en_i)
    begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // write-first: a read of the register being written sees the new value
  assign hit1 = wr_en_i && (wr_addr_i == rd_addr1_i);
  assign hit2 = wr_en_i && (wr_addr_i == rd_addr2_i);

  assign rd_data1_o = hit1 ? wr_data_i : regs[rd_addr1_i];
  assign rd_data2_o = hit2 ? wr_data_i : regs[rd_addr2_i];

endmodule

`default_nettype wire

//--- logic/branch_cond.sv
`timescale 1ns/1ps
`default_nettype none

module branch_cond (
  input  wire isa_pkg::op_t    op_i,
  input  wire exec_pkg::ccr_t  ccr_i,
  output logic                 taken_o
);

  logic ltu;
  logic lt;
  logic eq;

  assign ltu = ccr_i[exec_pkg::CCR_LTU];
  assign lt  = ccr_i[exec_pkg::CCR_LT];
  assign eq  = ccr_i[exec_pkg::CCR_EQ];

  always_comb
  begin
    case (op_i)
      4'h0:    taken_o = 1'b1;          // bra
      4'h1:    taken_o = eq;            // beq
      4'h2:    taken_o = !eq;           // bne
      4'h3:    taken_o = !(ltu || eq);  // bgtu
      4'h4:    taken_o = !(lt || eq);   // bgt
      4'h5:    taken_o = !lt;           // bge
      4'h6:    taken_o = lt || eq;      // ble
      4'h7:    taken_o = lt;            // blt
      4'h8:    taken_o = !ltu;          // bgeu
      4'h9:    taken_o = ltu;           // bltu
      4'ha:    taken_o = ltu || eq;     // bleu
      default: taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/int_calc.sv
`timescale 1ns/1ps
`default_nettype none

module int_calc (
  input  wire exec_pkg::int_func_t  func_i,
  input  wire isa_pkg::word_t       in1_i,
  input  wire isa_pkg::word_t       in2_i,
  output isa_pkg::word_t            out_o
);

  logic signed [31:0] s1;
  logic signed [31:0] s2;
  logic               div_zero;

  assign s1       = in1_i;
  assign s2       = in2_i;
  assign div_zero = (in2_i == '0);

  always_comb
  begin
    case (func_i)
      exec_pkg::INT_MUL:  out_o = isa_pkg::word_t'(s1 * s2);
      exec_pkg::INT_DIV:  out_o = div_zero ? '1 : isa_pkg::word_t'(s1 / s2);
      exec_pkg::INT_MOD:  out_o = div_zero ? in1_i : isa_pkg::word_t'(s1 % s2);
      exec_pkg::INT_MULU: out_o = isa_pkg::word_t'(in1_i * in2_i);
      exec_pkg::INT_DIVU: out_o = div_zero ? '1 : in1_i / in2_i;
      exec_pkg::INT_MODU: out_o = div_zero ? in1_i : in1_i % in2_i;
      default:            out_o = '0;
    endcase
  end

  // execute parks func_i at INT_MUL outside integer instructions,
  // so any other code here comes from a T_INT / T_INTU opcode
  always_comb
  begin
    if (!$isunknown(func_i))
    begin
      a_func_defined: assert final (func_i inside {exec_pkg::INT_MUL, exec_pkg::INT_DIV,
                                                  exec_pkg::INT_MOD, exec_pkg::INT_MULU,
                                                  exec_pkg::INT_DIVU, exec_pkg::INT_MODU})
        else $error("int_calc: undefined integer function %0h", func_i);
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_comb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_comb (
  input  wire isa_pkg::word_t       in1_i,
  input  wire isa_pkg::word_t       in2_i,
  input  wire exec_pkg::alu_func_t  func_i,
  output isa_pkg::word_t            out_o,
  output logic                      c_o,
  output logic                      z_o,
  output logic                      n_o,
  output logic                      v_o
);

  logic [32:0] sum;
  logic [32:0] diff;

  assign sum  = {1'b0, in1_i} + {1'b0, in2_i};
  assign diff = {1'b0, in1_i} - {1'b0, in2_i}; // msb is the borrow

  always_comb
  begin
    out_o = '0;
    c_o   = 1'b0;
    v_o   = 1'b0;
    case (func_i)
      exec_pkg::ALU_ADD:
      begin
        out_o = sum[31:0];
        c_o   = sum[32];
        v_o   = (in1_i[31] == in2_i[31]) && (sum[31] != in1_i[31]);
      end
      exec_pkg::ALU_SUB:
      begin
        out_o = diff[31:0];
        c_o   = diff[32];
        v_o   = (in1_i[31] != in2_i[31]) && (diff[31] != in1_i[31]);
      end
      exec_pkg::ALU_AND: out_o = in1_i & in2_i;
      exec_pkg::ALU_OR:  out_o = in1_i | in2_i;
      exec_pkg::ALU_XOR: out_o = in1_i ^ in2_i;
      exec_pkg::ALU_SHL: out_o = in1_i << in2_i[4:0];
      exec_pkg::ALU_SHR: out_o = in1_i >> in2_i[4:0];
      exec_pkg::ALU_ASR: out_o = isa_pkg::word_t'($signed(in1_i) >>> in2_i[4:0]);
      default:           out_o = '0;
    endcase
  end

  assign z_o = (out_o == '0);
  assign n_o = out_o[31];

endmodule

`default_nettype wire

//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SHL = 3'd5,
    ALU_SHR = 3'd6,
    ALU_ASR = 3'd7
  } alu_func_t;

  typedef enum logic [3:0] {
    INT_MUL  = 4'd0,
    INT_DIV  = 4'd1,
    INT_MOD  = 4'd2,
    INT_MULU = 4'd4,
    INT_DIVU = 4'd5,
    INT_MODU = 4'd6
  } int_func_t;

  typedef logic [2:0] ccr_t;
  typedef logic [3:0] delay_t;

  localparam int CCR_LTU = 2;
  localparam int CCR_LT  = 1;
  localparam int CCR_EQ  = 0;

endpackage

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int WORD_W    = 32;
  localparam int INSN_W    = 64;
  localparam int REG_IDX_W = 4;
  localparam int TYPE_W    = 4;
  localparam int OP_W      = 4;
  localparam int IMM_W     = 15;

  // bit positions inside the instruction word
  localparam int EXT_LSB  = 32;
  localparam int TYPE_LSB = 28;
  localparam int OP_LSB   = 24;
  localparam int RA_LSB   = 20;
  localparam int RB_LSB   = 16;
  localparam int RC_LSB   = 12;
  localparam int IMM_LSB  = 1;
  localparam int SIZE_BIT = 0;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [INSN_W-1:0]    insn_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [OP_W-1:0]      op_t;
  typedef logic [IMM_W-1:0]     imm_t;

  localparam op_t HALT_OP = 4'h4; // T_INH halt

  typedef enum logic [TYPE_W-1:0] {
    T_INH    = 4'd0,
    T_ALU    = 4'd1,
    T_CMP    = 4'd2,
    T_INT    = 4'd3,
    T_INTU   = 4'd4,
    T_LOAD   = 4'd5,
    T_STORE  = 4'd6,
    T_BRANCH = 4'd7,
    T_JUMP   = 4'd8,
    T_LDI    = 4'd9,
    T_MOV    = 4'd10
  } insn_type_t;

endpackage

`default_nettype wire

//--- include/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// architectural register count
`define EXEC_NUM_REGS 16

// stall counter load value for T_INT / T_INTU
`define EXEC_INT_DELAY 4

`endif
